//--- Makefile
VERILATOR ?= verilator
TOP ?= tb_buck_pmp
FILELIST ?= vlog.f
BUILD_DIR ?= obj_dir
VERILATOR_FLAGS ?= --binary --timing --assert -Wno-fatal
PASS_MSG ?= all tests passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build with Verilator, run the testbench, check for the pass message"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VERILATOR_FLAGS PASS_MSG"

test:
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

//--- buck_pre_modulation_processor.sv
// Top level with plain ports; setpoint levels must stay stable while the update burst they feed runs
`timescale 1ns/100ps

module buck_pre_modulation_processor (
    input logic clock,
    input logic arst_n,
    input logic configure,
    input logic start,
    input logic stop,
    input logic [3:0] update,
    input pmp_pkg::reg_data_t period,
    input pmp_pkg::reg_data_t deadtime,
    input pmp_pkg::reg_data_t duty [pmp_pkg::n_phases],
    input pmp_pkg::reg_data_t phase_shift [pmp_pkg::n_phases],
    output logic done,
    output logic modulator_status,
    output logic [pmp_pkg::n_phases-1:0] pwm_high,
    output logic [pmp_pkg::n_phases-1:0] pwm_low
);

    // Sequencer to FIFO, then FIFO to the register bank
    reg_write_if seq_wr ();
    reg_write_if bank_wr ();

    pmp_command_sequencer command_sequencer_i (
        .clock(clock),
        .arst_n(arst_n),
        .configure(configure),
        .start(start),
        .stop(stop),
        .update(update),
        .period(period),
        .deadtime(deadtime),
        .duty(duty),
        .phase_shift(phase_shift),
        .done(done),
        .modulator_status(modulator_status),
        .wr(seq_wr.source)
    );

    pmp_write_fifo write_fifo_i (
        .clock(clock),
        .arst_n(arst_n),
        .wr_in(seq_wr.sink),
        .wr_out(bank_wr.source)
    );

    pwm_register_bank register_bank_i (
        .clock(clock),
        .arst_n(arst_n),
        .wr(bank_wr.sink),
        .pwm_high(pwm_high),
        .pwm_low(pwm_low)
    );

endmodule

//--- pmp_command_sequencer.sv
// Purely combinational merge; a management write can be displaced by an operating write while waiting
`timescale 1ns/100ps

module pmp_command_sequencer (
    input logic clock,
    input logic arst_n,
    input logic configure,
    input logic start,
    input logic stop,
    input logic [3:0] update,
    input pmp_pkg::reg_data_t period,
    input pmp_pkg::reg_data_t deadtime,
    input pmp_pkg::reg_data_t duty [pmp_pkg::n_phases],
    input pmp_pkg::reg_data_t phase_shift [pmp_pkg::n_phases],
    output logic done,
    output logic modulator_status,
    reg_write_if.source wr
);

    reg_write_if mgmt_wr ();
    reg_write_if op_wr ();

    logic pwm_config_done;
    logic sel_operating;

    pmp_management_core management_core_i (
        .clock(clock),
        .arst_n(arst_n),
        .configure(configure),
        .start(start),
        .stop(stop),
        .deadtime(deadtime),
        .done(done),
        .modulator_status(modulator_status),
        .pwm_config_done(pwm_config_done),
        .wr(mgmt_wr.source)
    );

    pmp_operating_core operating_core_i (
        .clock(clock),
        .arst_n(arst_n),
        .pwm_config_done(pwm_config_done),
        .update(update),
        .period(period),
        .duty(duty),
        .phase_shift(phase_shift),
        .wr(op_wr.source)
    );

    // The operating core owns the path whenever it has a write
    assign sel_operating = op_wr.valid;

    assign wr.valid = op_wr.valid || mgmt_wr.valid;
    assign wr.addr = sel_operating ? op_wr.addr : mgmt_wr.addr;
    assign wr.data = sel_operating ? op_wr.data : mgmt_wr.data;

    assign op_wr.ready = wr.ready && sel_operating;
    assign mgmt_wr.ready = wr.ready && !sel_operating;

endmodule

//--- pmp_management_core.sv
// Serves configure, start and stop one write at a time in that order; deadtime is sampled at issue
`timescale 1ns/100ps

module pmp_management_core (
    input logic clock,
    input logic arst_n,
    input logic configure,
    input logic start,
    input logic stop,
    input pmp_pkg::reg_data_t deadtime,
    output logic done,
    output logic modulator_status,
    output logic pwm_config_done,
    reg_write_if.source wr
);

    typedef enum logic {
        st_idle,
        st_write
    } state_t;

    typedef enum logic [1:0] {
        op_configure,
        op_start,
        op_stop
    } op_t;

    state_t state;
    op_t cur_op;
    pmp_pkg::reg_write_t req;
    logic pend_cfg, pend_start, pend_stop;
    logic issue_cfg, issue_start, issue_stop;
    logic accept;

    // Pending requests are served with configure first, then start, then stop
    assign issue_cfg = (state == st_idle) && pend_cfg;
    assign issue_start = (state == st_idle) && !pend_cfg && pend_start;
    assign issue_stop = (state == st_idle) && !pend_cfg && !pend_start && pend_stop;
    assign accept = wr.valid && wr.ready;

    assign wr.valid = (state == st_write);
    assign wr.addr = req.addr;
    assign wr.data = req.data;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            state <= st_idle;
            cur_op <= op_configure;
            req <= '0;
            pend_cfg <= 1'b0;
            pend_start <= 1'b0;
            pend_stop <= 1'b0;
            done <= 1'b0;
            modulator_status <= 1'b0;
            pwm_config_done <= 1'b0;
        end else begin
            done <= 1'b0;
            // A strobe that lands in the issue cycle stays pending for a later write
            pend_cfg <= (pend_cfg && !issue_cfg) || configure;
            pend_start <= (pend_start && !issue_start) || start;
            pend_stop <= (pend_stop && !issue_stop) || stop;

            if (state == st_write) begin
                if (accept) begin
                    state <= st_idle;
                    case (cur_op)
                        op_configure: begin
                            done <= 1'b1;
                            pwm_config_done <= 1'b1;
                        end
                        op_start: modulator_status <= 1'b1;
                        default: modulator_status <= 1'b0;
                    endcase
                end
            end else if (issue_cfg) begin
                state <= st_write;
                cur_op <= op_configure;
                req <= '{addr: pmp_pkg::addr_deadtime, data: deadtime};
            end else if (issue_start) begin
                state <= st_write;
                cur_op <= op_start;
                req <= '{addr: pmp_pkg::addr_control, data: pmp_pkg::ctrl_run};
            end else if (issue_stop) begin
                state <= st_write;
                cur_op <= op_stop;
                req <= '{addr: pmp_pkg::addr_control, data: pmp_pkg::ctrl_stop};
            end
        end
    end

endmodule

//--- pmp_operating_core.sv
// Setpoint inputs are read while a write is presented, so they must stay stable during a burst
`timescale 1ns/100ps

module pmp_operating_core (
    input logic clock,
    input logic arst_n,
    input logic pwm_config_done,
    input logic [3:0] update,
    input pmp_pkg::reg_data_t period,
    input pmp_pkg::reg_data_t duty [pmp_pkg::n_phases],
    input pmp_pkg::reg_data_t phase_shift [pmp_pkg::n_phases],
    reg_write_if.source wr
);

    logic [pmp_pkg::n_slots-1:0] pending;
    logic [pmp_pkg::n_slots-1:0] pending_next;
    logic [pmp_pkg::n_slots-1:0] req_mask;
    pmp_pkg::slot_t slot;
    pmp_pkg::slot_t shift_slot;
    pmp_pkg::phase_t phase_sel;
    logic accept;

    assign accept = wr.valid && wr.ready;

    // Strobes are ignored until the deadtime has been configured
    always_comb begin
        req_mask = '0;
        if (pwm_config_done) begin
            if (update[0] || update[3]) begin
                req_mask[pmp_pkg::n_phases-1:0] = '1;
            end
            if (update[1] || update[3]) begin
                req_mask[pmp_pkg::slot_period] = 1'b1;
            end
            if (update[2] || update[3]) begin
                req_mask[pmp_pkg::n_slots-1:pmp_pkg::slot_period+1] = '1;
            end
        end
    end

    // Clear before merging so a new strobe on the served slot is kept
    always_comb begin
        pending_next = pending;
        if (accept) begin
            pending_next[slot] = 1'b0;
        end
        pending_next = pending_next | req_mask;
    end

    assign shift_slot = slot - pmp_pkg::slot_t'(pmp_pkg::slot_period + 1);

    // Address and data follow the slot index
    always_comb begin
        if (slot < pmp_pkg::slot_t'(pmp_pkg::n_phases)) begin
            phase_sel = slot[pmp_pkg::phase_w-1:0];
            wr.addr = pmp_pkg::addr_duty_base + pmp_pkg::reg_addr_t'(phase_sel);
            wr.data = duty[phase_sel];
        end else if (slot == pmp_pkg::slot_t'(pmp_pkg::slot_period)) begin
            phase_sel = '0;
            wr.addr = pmp_pkg::addr_period;
            wr.data = period;
        end else begin
            phase_sel = shift_slot[pmp_pkg::phase_w-1:0];
            wr.addr = pmp_pkg::addr_shift_base + pmp_pkg::reg_addr_t'(phase_sel);
            wr.data = phase_shift[phase_sel];
        end
    end

    assign wr.valid = pending[slot];

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            pending <= '0;
            slot <= '0;
        end else begin
            pending <= pending_next;
            // An idle core parks on the first duty slot so each burst starts in order
            if (pending == '0) begin
                slot <= '0;
            end else if (!pending[slot] || accept) begin
                if (slot == pmp_pkg::slot_t'(pmp_pkg::n_slots - 1)) begin
                    slot <= '0;
                end else begin
                    slot <= slot + 1'b1;
                end
            end
        end
    end

endmodule

//--- pmp_pkg.sv
// Four phases, fixed register map, FIFO depth 8; the operating core slot order assumes duty, period, shift
package pmp_pkg;

    localparam int n_phases = 4;
    localparam int phase_w = $clog2(n_phases);

    typedef logic [7:0] reg_addr_t;
    typedef logic [15:0] reg_data_t;
    typedef logic [phase_w-1:0] phase_t;

    // One register write as carried through the FIFO
    typedef struct packed {
        reg_addr_t addr;
        reg_data_t data;
    } reg_write_t;

    // Register map of the PWM bank
    localparam reg_addr_t addr_period = 8'h00;
    localparam reg_addr_t addr_deadtime = 8'h01;
    localparam reg_addr_t addr_control = 8'h02;
    localparam reg_addr_t addr_duty_base = 8'h10;
    localparam reg_addr_t addr_shift_base = 8'h20;

    // Control register fields
    localparam int run_bit = 0;
    localparam reg_data_t ctrl_run = reg_data_t'(1) << run_bit;
    localparam reg_data_t ctrl_stop = '0;

    // Operating core write slots: duty 0..n-1, then period, then shift 0..n-1
    localparam int n_slots = 2 * n_phases + 1;
    localparam int slot_period = n_phases;
    localparam int slot_w = $clog2(n_slots);
    typedef logic [slot_w-1:0] slot_t;

    // Write FIFO sizing
    localparam int write_fifo_depth = 8;
    typedef logic [$clog2(write_fifo_depth)-1:0] fifo_ptr_t;
    typedef logic [$clog2(write_fifo_depth+1)-1:0] fifo_count_t;

endpackage

//--- pmp_props.sv
// Bound to the top level; outputs must be quiet one period plus the FIFO depth after a stop
`timescale 1ns/100ps

module pmp_props (
    input logic clock,
    input logic arst_n,
    input logic done,
    input logic modulator_status,
    input pmp_pkg::reg_data_t period,
    input logic [pmp_pkg::n_phases-1:0] pwm_high,
    input logic [pmp_pkg::n_phases-1:0] pwm_low
);

    logic [16:0] stopped_cycles;
    logic [16:0] stop_limit;

    // The last commit after a stop can come up to one period after the FIFO drains
    assign stop_limit = {1'b0, period} + 17'(pmp_pkg::write_fifo_depth) + 17'd2;

    // Cycles since modulator_status was last high, saturating
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            stopped_cycles <= '0;
        end else if (modulator_status) begin
            stopped_cycles <= '0;
        end else if (stopped_cycles != '1) begin
            stopped_cycles <= stopped_cycles + 17'd1;
        end
    end

    no_overlap: assert property (@(posedge clock) disable iff (!arst_n)
        (pwm_high & pwm_low) == '0)
        else $error("high-side and low-side outputs of one phase are on together");

    stopped_quiet: assert property (@(posedge clock) disable iff (!arst_n)
        (stopped_cycles > stop_limit) |-> (pwm_high == '0 && pwm_low == '0))
        else $error("pwm outputs switch while the modulator is stopped");

    reset_quiet: assert property (@(posedge clock)
        !arst_n |-> (!done && !modulator_status && pwm_high == '0 && pwm_low == '0))
        else $error("outputs are not low during reset");

endmodule

bind buck_pre_modulation_processor pmp_props pmp_props_i (
    .clock(clock),
    .arst_n(arst_n),
    .done(done),
    .modulator_status(modulator_status),
    .period(period),
    .pwm_high(pwm_high),
    .pwm_low(pwm_low)
);

//--- pmp_write_fifo.sv
// Registered-output write FIFO; no bypass, so a write needs at least one cycle to pass through
`timescale 1ns/100ps

module pmp_write_fifo (
    input logic clock,
    input logic arst_n,
    reg_write_if.sink wr_in,
    reg_write_if.source wr_out
);

    pmp_pkg::reg_write_t mem [pmp_pkg::write_fifo_depth];
    pmp_pkg::fifo_ptr_t wr_ptr;
    pmp_pkg::fifo_ptr_t rd_ptr;
    pmp_pkg::fifo_count_t count;
    logic push;
    logic pop;

    localparam pmp_pkg::fifo_ptr_t last_ptr =
        pmp_pkg::fifo_ptr_t'(pmp_pkg::write_fifo_depth - 1);

    assign wr_in.ready = (count != pmp_pkg::fifo_count_t'(pmp_pkg::write_fifo_depth));
    assign wr_out.valid = (count != '0);
    assign wr_out.addr = mem[rd_ptr].addr;
    assign wr_out.data = mem[rd_ptr].data;

    assign push = wr_in.valid && wr_in.ready;
    assign pop = wr_out.valid && wr_out.ready;

    // Storage
    always_ff @(posedge clock) begin
        if (push) begin
            mem[wr_ptr] <= '{addr: wr_in.addr, data: wr_in.data};
        end
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == last_ptr) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == last_ptr) ? '0 : rd_ptr + 1'b1;
            end
            // Simultaneous push and pop leave the fill level unchanged
            case ({push, pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

//--- pwm_register_bank.sv
// Assumes shift < period and duty + deadtime < period; while stopped, staged values apply at once
`timescale 1ns/100ps

module pwm_register_bank (
    input logic clock,
    input logic arst_n,
    reg_write_if.sink wr,
    output logic [pmp_pkg::n_phases-1:0] pwm_high,
    output logic [pmp_pkg::n_phases-1:0] pwm_low
);

    pmp_pkg::reg_data_t period_s, period_a;
    pmp_pkg::reg_data_t deadtime_s, deadtime_a;
    pmp_pkg::reg_data_t duty_s [pmp_pkg::n_phases];
    pmp_pkg::reg_data_t duty_a [pmp_pkg::n_phases];
    pmp_pkg::reg_data_t shift_s [pmp_pkg::n_phases];
    pmp_pkg::reg_data_t shift_a [pmp_pkg::n_phases];
    logic run_s, run_a;
    pmp_pkg::reg_data_t base_cnt;
    logic [16:0] base_inc;
    logic wrap;
    logic commit;
    logic [16:0] phase_sum [pmp_pkg::n_phases];
    logic [16:0] low_start [pmp_pkg::n_phases];
    pmp_pkg::reg_data_t phase_cnt [pmp_pkg::n_phases];

    // The bank never stalls the write path
    assign wr.ready = 1'b1;

    assign base_inc = {1'b0, base_cnt} + 17'd1;
    assign wrap = run_a && (base_inc >= {1'b0, period_a});
    assign commit = wrap || !run_a;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            period_s <= '0;
            deadtime_s <= '0;
            run_s <= 1'b0;
            duty_s <= '{default: '0};
            shift_s <= '{default: '0};
        end else if (wr.valid) begin
            // Unknown addresses fall through every compare and are dropped
            if (wr.addr == pmp_pkg::addr_period) begin
                period_s <= wr.data;
            end
            if (wr.addr == pmp_pkg::addr_deadtime) begin
                deadtime_s <= wr.data;
            end
            if (wr.addr == pmp_pkg::addr_control) begin
                run_s <= wr.data[pmp_pkg::run_bit];
            end
            for (int k = 0; k < pmp_pkg::n_phases; k++) begin
                if (wr.addr == pmp_pkg::addr_duty_base + pmp_pkg::reg_addr_t'(k)) begin
                    duty_s[k] <= wr.data;
                end
                if (wr.addr == pmp_pkg::addr_shift_base + pmp_pkg::reg_addr_t'(k)) begin
                    shift_s[k] <= wr.data;
                end
            end
        end
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            period_a <= '0;
            deadtime_a <= '0;
            run_a <= 1'b0;
            duty_a <= '{default: '0};
            shift_a <= '{default: '0};
            base_cnt <= '0;
        end else begin
            if (commit) begin
                period_a <= period_s;
                deadtime_a <= deadtime_s;
                run_a <= run_s;
                duty_a <= duty_s;
                shift_a <= shift_s;
            end
            // Base counter sits at zero while stopped
            if (!run_a || wrap) begin
                base_cnt <= '0;
            end else begin
                base_cnt <= base_inc[15:0];
            end
        end
    end

    always_comb begin
        for (int k = 0; k < pmp_pkg::n_phases; k++) begin
            phase_sum[k] = {1'b0, base_cnt} + {1'b0, shift_a[k]};
            if (phase_sum[k] >= {1'b0, period_a}) begin
                phase_sum[k] = phase_sum[k] - {1'b0, period_a};
            end
            phase_cnt[k] = phase_sum[k][15:0];
            low_start[k] = {1'b0, duty_a[k]} + {1'b0, deadtime_a};
            pwm_high[k] = run_a && (phase_cnt[k] >= deadtime_a) && (phase_cnt[k] < duty_a[k]);
            pwm_low[k] = run_a && ({1'b0, phase_cnt[k]} >= low_start[k])
                && (phase_cnt[k] < period_a);
        end
    end

endmodule

//--- reg_write_if.sv
// Valid/ready register write channel; the source must hold addr and data while valid waits for ready
`timescale 1ns/100ps

interface reg_write_if;

    logic valid;
    logic ready;
    pmp_pkg::reg_addr_t addr;
    pmp_pkg::reg_data_t data;

    // The side that issues writes
    modport source (
        output valid,
        output addr,
        output data,
        input ready
    );

    // The side that accepts writes
    modport sink (
        input valid,
        input addr,
        input data,
        output ready
    );

endinterface

//--- tb_buck_pmp.sv
// Fixed setpoints with period 40 and deadtime 3; checks need --assert and stop at the first failure
`timescale 1ns/100ps

module tb_buck_pmp;

    logic clock;
    logic arst_n;
    logic configure;
    logic start;
    logic stop;
    logic [3:0] update;
    pmp_pkg::reg_data_t period;
    pmp_pkg::reg_data_t deadtime;
    pmp_pkg::reg_data_t duty [pmp_pkg::n_phases];
    pmp_pkg::reg_data_t phase_shift [pmp_pkg::n_phases];
    logic done;
    logic modulator_status;
    logic [pmp_pkg::n_phases-1:0] pwm_high;
    logic [pmp_pkg::n_phases-1:0] pwm_low;

    int setpoint_period;
    int setpoint_deadtime;
    int timeout_cycles;
    int stop_settle;
    int duty_ref [pmp_pkg::n_phases];
    int shift_ref [pmp_pkg::n_phases];
    int high_count [pmp_pkg::n_phases];
    int low_count [pmp_pkg::n_phases];
    int rise_offset [pmp_pkg::n_phases];
    int done_count;
    int stopped_cycles;
    int cycle_count;
    logic [31:0] rng_state;

    buck_pre_modulation_processor buck_pre_modulation_processor_i (
        .clock(clock),
        .arst_n(arst_n),
        .configure(configure),
        .start(start),
        .stop(stop),
        .update(update),
        .period(period),
        .deadtime(deadtime),
        .duty(duty),
        .phase_shift(phase_shift),
        .done(done),
        .modulator_status(modulator_status),
        .pwm_high(pwm_high),
        .pwm_low(pwm_low)
    );

    // 8 ns clock period
    always #4 clock = ~clock;

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("tests failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input int expected, input int actual);
        assert (actual == expected)
            else abort_run($sformatf("error %s expected %0d actual %0d", name, expected, actual));
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] value);
        logic [31:0] x;
        x = value;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic send_command(input logic cfg, input logic run, input logic halt);
        configure = cfg;
        start = run;
        stop = halt;
        @(negedge clock);
        configure = 1'b0;
        start = 1'b0;
        stop = 1'b0;
    endtask

    task automatic pulse_update(input logic [3:0] bits);
        update = bits;
        @(negedge clock);
        update = '0;
    endtask

    task automatic wait_done();
        while (!done) @(negedge clock);
    endtask

    task automatic wait_status(input logic level);
        while (modulator_status != level) @(negedge clock);
    endtask

    task automatic count_active(input int cycles, output int active);
        active = 0;
        for (int i = 0; i < cycles; i++) begin
            if (pwm_high != '0 || pwm_low != '0) active++;
            @(negedge clock);
        end
    endtask

    // One window of a full period that opens on the rise of phase 0, with an optional
    // update strobe driven one cycle into the window
    task automatic measure_period(input logic [3:0] strobe_bits);
        logic [pmp_pkg::n_phases-1:0] last_high;
        last_high = pwm_high;
        @(negedge clock);
        while (!(pwm_high[0] && !last_high[0])) begin
            last_high = pwm_high;
            @(negedge clock);
        end
        for (int k = 0; k < pmp_pkg::n_phases; k++) begin
            high_count[k] = 0;
            low_count[k] = 0;
            rise_offset[k] = -1;
        end
        for (int i = 0; i < setpoint_period; i++) begin
            for (int k = 0; k < pmp_pkg::n_phases; k++) begin
                if (pwm_high[k]) high_count[k]++;
                if (pwm_low[k]) low_count[k]++;
                if (pwm_high[k] && !last_high[k] && rise_offset[k] < 0) rise_offset[k] = i;
            end
            last_high = pwm_high;
            update = (i == 1) ? strobe_bits : 4'b0000;
            if (i < setpoint_period - 1) @(negedge clock);
        end
        update = '0;
    endtask

    task automatic check_full_period(input string name);
        int rise;
        measure_period(4'b0000);
        for (int k = 0; k < pmp_pkg::n_phases; k++) begin
            rise = (shift_ref[0] - shift_ref[k] + setpoint_period) % setpoint_period;
            check_value($sformatf("%s high phase %0d", name, k),
                duty_ref[k] - setpoint_deadtime, high_count[k]);
            check_value($sformatf("%s low phase %0d", name, k),
                setpoint_period - duty_ref[k] - setpoint_deadtime, low_count[k]);
            check_value($sformatf("%s rise phase %0d", name, k), rise, rise_offset[k]);
        end
    endtask

    // Output sanity on every cycle, and the done count for the configure test
    always @(negedge clock) begin
        if (done) done_count++;
        if (modulator_status) stopped_cycles = 0;
        else stopped_cycles++;
        if (arst_n) begin
            assert ((pwm_high & pwm_low) == '0)
                else abort_run("deadtime: high-side and low-side outputs of a phase are on together");
            assert (stopped_cycles <= stop_settle || (pwm_high == '0 && pwm_low == '0))
                else abort_run("stop: pwm outputs still switch long after modulator_status fell");
        end
    end

    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count > timeout_cycles) begin
            abort_run("timeout: the run did not reach its end within the cycle limit");
        end
    end

    initial begin
        int active;
        int old_width;
        setpoint_period = 40;
        setpoint_deadtime = 3;
        // About 60 periods of 40 cycles plus margin
        timeout_cycles = 4000;
        stop_settle = setpoint_period + pmp_pkg::write_fifo_depth + 2;
        duty_ref = '{12, 16, 20, 24};
        shift_ref = '{0, 10, 20, 30};
        done_count = 0;
        stopped_cycles = 0;
        cycle_count = 0;
        rng_state = 32'h09659572;
        clock = 1'b0;
        arst_n = 1'b0;
        configure = 1'b0;
        start = 1'b0;
        stop = 1'b0;
        update = '0;
        period = pmp_pkg::reg_data_t'(setpoint_period);
        deadtime = pmp_pkg::reg_data_t'(setpoint_deadtime);
        for (int k = 0; k < pmp_pkg::n_phases; k++) begin
            duty[k] = pmp_pkg::reg_data_t'(duty_ref[k]);
            phase_shift[k] = pmp_pkg::reg_data_t'(shift_ref[k]);
        end
        repeat (10) @(posedge clock);
        @(negedge clock);
        arst_n = 1'b1;
        @(negedge clock);

        // An update ahead of configure must be dropped by the operating core
        pulse_update(4'b1000);
        send_command(1'b1, 1'b0, 1'b0);
        wait_done();
        repeat (20) @(negedge clock);
        check_value("configure done count", 1, done_count);
        send_command(1'b0, 1'b1, 1'b0);
        wait_status(1'b1);
        count_active(2 * setpoint_period, active);
        check_value("configure ignored update", 0, active);

        // Load all nine registers while stopped, then run
        send_command(1'b0, 1'b0, 1'b1);
        wait_status(1'b0);
        pulse_update(4'b1000);
        send_command(1'b0, 1'b1, 1'b0);
        wait_status(1'b1);
        check_full_period("start_run");
        check_full_period("phase_shift");

        // New duty set lands mid-period, so phase 0 keeps its old width for that period
        old_width = duty_ref[0] - setpoint_deadtime;
        for (int k = 0; k < pmp_pkg::n_phases; k++) begin
            rng_state = xorshift32(rng_state);
            duty_ref[k] = 8 + int'(rng_state % 32'd23);
            duty[k] = pmp_pkg::reg_data_t'(duty_ref[k]);
        end
        measure_period(4'b0001);
        check_value("boundary_update old width phase 0", old_width, high_count[0]);
        check_full_period("boundary_update");

        send_command(1'b0, 1'b0, 1'b1);
        wait_status(1'b0);
        repeat (stop_settle) @(negedge clock);
        count_active(2 * setpoint_period, active);
        check_value("stop active cycles", 0, active);

        $display("all tests passed");
        $finish;
    end

endmodule

//--- vlog.f
pmp_pkg.sv
reg_write_if.sv
pmp_management_core.sv
pmp_operating_core.sv
pmp_command_sequencer.sv
pmp_write_fifo.sv
pwm_register_bank.sv
buck_pre_modulation_processor.sv
pmp_props.sv
tb_buck_pmp.sv
